// File: Makefile
# Verilator build and run for the triangle scene testbench

VERILATOR ?= verilator
TOP ?= tb_render
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
FAIL_MSG ?= STATUS: FAIL
PASS_MSG ?= STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without passing"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
rtl/raster_pkg.sv
rtl/draw_ifs.sv
rtl/shape_table.sv
rtl/scene_sequencer.sv
rtl/triangle_drawer.sv
rtl/line_drawer.sv
rtl/render_top.sv
test/tb_clock.sv
test/render_properties.sv
test/tb_render.sv

// File: rtl/draw_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~
// drawing interfaces: triangle and line request channels
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

// sequencer to triangle drawer
interface tri_if;

    logic start;                 // one-cycle request strobe
    raster_pkg::vertex_t v0;
    raster_pkg::vertex_t v1;
    raster_pkg::vertex_t v2;
    logic done;                  // one-cycle completion strobe

    modport src (output start, output v0, output v1, output v2, input done);
    modport dst (input start, input v0, input v1, input v2, output done);

endinterface

// triangle drawer to line drawer
interface line_if;

    logic start;                 // one-cycle request strobe
    raster_pkg::vertex_t p0;     // first pixel of the line
    raster_pkg::vertex_t p1;     // last pixel of the line
    logic done;                  // one-cycle completion strobe

    modport src (output start, output p0, output p1, input done);
    modport dst (input start, input p0, input p1, output done);

endinterface

// File: rtl/line_drawer.sv
// ~~~~~~~~~~~~~~~~~~~~
// line drawer: Bresenham stepper, one pixel per enabled cycle
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module line_drawer (
    input  logic clk,
    input  logic rst,
    input  logic oe,
    line_if.dst line,
    output raster_pkg::coord_t x,
    output raster_pkg::coord_t y,
    output logic drawing
);

    typedef enum logic [1:0] {st_idle, st_setup, st_draw, st_end} state_t;

    state_t state;

    // error term needs headroom for 2*err on a full-range line
    logic signed [raster_pkg::coord_w+2:0] diff_x, diff_y;
    logic signed [raster_pkg::coord_w+2:0] abs_x, abs_y;
    logic signed [raster_pkg::coord_w+2:0] dx, dy;  // |dx| and -|dy|
    logic signed [raster_pkg::coord_w+2:0] err, e2;
    logic sx, sy;                                   // 1 steps toward negative
    logic step_x, step_y;
    logic at_end;

    function automatic logic signed [raster_pkg::coord_w+2:0] widen(
        input raster_pkg::coord_t c
    );
        return $signed({{3{c[raster_pkg::coord_w-1]}}, c});
    endfunction

    always_comb begin
        diff_x = widen(line.p1.x) - widen(line.p0.x);
        diff_y = widen(line.p1.y) - widen(line.p0.y);
        abs_x = diff_x[raster_pkg::coord_w+2] ? -diff_x : diff_x;
        abs_y = diff_y[raster_pkg::coord_w+2] ? -diff_y : diff_y;
        e2 = err <<< 1;
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        at_end = (x == line.p1.x) && (y == line.p1.y);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (line.start) begin
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    if (oe) begin
                        state <= st_draw;
                    end
                end
                st_draw: begin
                    if (oe && at_end) begin
                        state <= st_end;  // p1 was just emitted
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // x and y only move under oe, so a stall never drops a pixel
    always_ff @(posedge clk) begin
        if (state == st_setup && oe) begin
            dx <= abs_x;
            dy <= -abs_y;
            sx <= diff_x[raster_pkg::coord_w+2];
            sy <= diff_y[raster_pkg::coord_w+2];
            err <= abs_x - abs_y;
            x <= line.p0.x;
            y <= line.p0.y;
        end else if (state == st_draw && oe && !at_end) begin
            err <= err + (step_x ? dy : '0) + (step_y ? dx : '0);
            if (step_x) begin
                x <= sx ? x - raster_pkg::coord_t'(1) : x + raster_pkg::coord_t'(1);
            end
            if (step_y) begin
                y <= sy ? y - raster_pkg::coord_t'(1) : y + raster_pkg::coord_t'(1);
            end
        end
    end

    assign drawing = (state == st_draw) && oe;
    assign line.done = (state == st_end);

endmodule

// File: rtl/raster_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// raster package: coordinate and colour widths, scene size, vertex type
// ~~~~~~~~~~~~~~~~~~~~

package raster_pkg;

    localparam int coord_w = 16;    // signed coordinate width
    localparam int cidx_w = 4;      // colour index width
    localparam int shape_cnt = 3;   // triangles in the scene
    localparam int shape_id_w = 2;  // shape number width

    typedef logic signed [coord_w-1:0] coord_t;
    typedef logic [cidx_w-1:0] cidx_t;

    // one screen position, x in the upper half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

endpackage

// File: rtl/render_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// render top: draws the outlined triangle scene as a pixel stream
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module render_top #(
    parameter int scale = 1  // 1, 2 or 4
) (
    input  logic clk,
    input  logic rst,
    input  logic oe,
    input  logic start,
    output raster_pkg::coord_t x,
    output raster_pkg::coord_t y,
    output raster_pkg::cidx_t cidx,
    output logic drawing,
    output logic done
);

    logic [raster_pkg::shape_id_w-1:0] shape_id;
    raster_pkg::vertex_t rom_v0, rom_v1, rom_v2;  // unscaled table output
    raster_pkg::cidx_t rom_colour;

    tri_if tri_bus ();
    line_if line_bus ();

    shape_table shape_table_i (
        .shape_id(shape_id),
        .v0(rom_v0),
        .v1(rom_v1),
        .v2(rom_v2),
        .colour(rom_colour)
    );

    scene_sequencer #(.scale(scale)) scene_sequencer_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .tri_bus(tri_bus.src),
        .shape_id(shape_id),
        .v0(rom_v0),
        .v1(rom_v1),
        .v2(rom_v2),
        .colour_in(rom_colour),
        .cidx(cidx),
        .done(done)
    );

    triangle_drawer triangle_drawer_i (
        .clk(clk),
        .rst(rst),
        .tri_bus(tri_bus.dst),
        .line(line_bus.src)
    );

    line_drawer line_drawer_i (
        .clk(clk),
        .rst(rst),
        .oe(oe),
        .line(line_bus.dst),
        .x(x),
        .y(y),
        .drawing(drawing)
    );

endmodule

// File: rtl/scene_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~
// scene sequencer: walks the shape table and hands each
// scaled triangle to the triangle drawer
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module scene_sequencer #(
    parameter int scale = 1  // 1, 2 or 4
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    tri_if.src tri_bus,
    output logic [raster_pkg::shape_id_w-1:0] shape_id,
    input  raster_pkg::vertex_t v0,
    input  raster_pkg::vertex_t v1,
    input  raster_pkg::vertex_t v2,
    input  raster_pkg::cidx_t colour_in,
    output raster_pkg::cidx_t cidx,
    output logic done
);

    typedef enum logic [1:0] {st_idle, st_init, st_draw, st_finished} state_t;

    state_t state;
    logic last_shape;

    // scale is a power of two, so a shift does the multiply
    function automatic raster_pkg::vertex_t scale_vertex(input raster_pkg::vertex_t v);
        raster_pkg::vertex_t s;
        s.x = v.x <<< $clog2(scale);
        s.y = v.y <<< $clog2(scale);
        return s;
    endfunction

    assign last_shape = (shape_id == raster_pkg::shape_id_w'(raster_pkg::shape_cnt - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            shape_id <= '0;
            tri_bus.start <= 1'b0;
        end else begin
            tri_bus.start <= 1'b0;  // strobe by default
            case (state)
                st_idle: begin
                    if (start) begin
                        shape_id <= '0;
                        state <= st_init;
                    end
                end
                st_init: begin
                    tri_bus.start <= 1'b1;  // vertices valid next cycle
                    state <= st_draw;
                end
                st_draw: begin
                    if (tri_bus.done) begin
                        if (last_shape) begin
                            state <= st_finished;
                        end else begin
                            shape_id <= shape_id + raster_pkg::shape_id_w'(1);
                            state <= st_init;
                        end
                    end
                end
                default: state <= st_finished;  // held until reset
            endcase
        end
    end

    // vertices stay put until the next init
    always_ff @(posedge clk) begin
        if (state == st_init) begin
            tri_bus.v0 <= scale_vertex(v0);
            tri_bus.v1 <= scale_vertex(v1);
            tri_bus.v2 <= scale_vertex(v2);
            cidx <= colour_in;
        end
    end

    // rises with the last triangle's done strobe, then held by state
    assign done = (state == st_finished) || (state == st_draw && tri_bus.done && last_shape);

endmodule

// File: rtl/shape_table.sv
// ~~~~~~~~~~~~~~~~~~~~
// shape table: scene ROM, three vertices and a colour per shape
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module shape_table (
    input  logic [raster_pkg::shape_id_w-1:0] shape_id,
    output raster_pkg::vertex_t v0,
    output raster_pkg::vertex_t v1,
    output raster_pkg::vertex_t v2,
    output raster_pkg::cidx_t colour
);

    function automatic raster_pkg::vertex_t vtx(input int px, input int py);
        raster_pkg::vertex_t v;
        v.x = raster_pkg::coord_t'(px);
        v.y = raster_pkg::coord_t'(py);
        return v;
    endfunction

    // coordinates are unscaled, 320x180 space
    always_comb begin
        case (shape_id)
            2'd0: begin
                v0 = vtx(60, 20);
                v1 = vtx(280, 80);
                v2 = vtx(160, 164);
                colour = raster_pkg::cidx_t'(3);
            end
            2'd1: begin
                v0 = vtx(70, 160);
                v1 = vtx(220, 90);
                v2 = vtx(170, 10);
                colour = raster_pkg::cidx_t'(2);
            end
            default: begin  // shape 2, id 3 unused
                v0 = vtx(22, 36);
                v1 = vtx(62, 150);
                v2 = vtx(98, 96);
                colour = raster_pkg::cidx_t'(1);
            end
        endcase
    end

endmodule

// File: rtl/triangle_drawer.sv
// ~~~~~~~~~~~~~~~~~~~~
// triangle drawer: outlines a triangle as three line requests
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module triangle_drawer (
    input  logic clk,
    input  logic rst,
    tri_if.dst tri_bus,
    line_if.src line
);

    typedef enum logic [2:0] {
        st_idle,
        st_start0,  // edge v0 -> v1
        st_wait0,
        st_start1,  // edge v1 -> v2
        st_wait1,
        st_start2,  // edge v2 -> v0
        st_wait2,
        st_done
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (tri_bus.start) begin
                        state <= st_start0;
                    end
                end
                st_start0: state <= st_wait0;
                st_wait0: begin
                    if (line.done) begin
                        state <= st_start1;
                    end
                end
                st_start1: state <= st_wait1;
                st_wait1: begin
                    if (line.done) begin
                        state <= st_start2;
                    end
                end
                st_start2: state <= st_wait2;
                st_wait2: begin
                    if (line.done) begin
                        state <= st_done;
                    end
                end
                default: state <= st_idle;  // st_done lasts one cycle
            endcase
        end
    end

    assign line.start = (state == st_start0) || (state == st_start1) || (state == st_start2);
    assign tri_bus.done = (state == st_done);

    // endpoints follow the edge being drawn
    always_comb begin
        case (state)
            st_start0, st_wait0: begin
                line.p0 = tri_bus.v0;
                line.p1 = tri_bus.v1;
            end
            st_start1, st_wait1: begin
                line.p0 = tri_bus.v1;
                line.p1 = tri_bus.v2;
            end
            default: begin
                line.p0 = tri_bus.v2;
                line.p1 = tri_bus.v0;
            end
        endcase
    end

endmodule

// File: test/render_properties.sv
// ~~~~~~~~~~~~~~~~~~~~
// render properties: reset, done and stall rules on the top level
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module render_properties (
    input logic clk,
    input logic rst,
    input logic oe,
    input raster_pkg::coord_t x,
    input raster_pkg::coord_t y,
    input logic drawing,
    input logic done
);

    // synchronous reset, so drawing is cleared from the first reset edge on
    no_drawing_in_reset: assert property (@(posedge clk) $past(rst) |-> !drawing)
        else $error("drawing high while in reset");

    done_held: assert property (@(posedge clk) $fell(done) |-> $past(rst))
        else $error("done fell without a reset");

    // a stalled cycle must not move the pixel position
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        !$past(oe) |-> $stable(x) && $stable(y))
        else $error("pixel position moved while oe was low");

endmodule

// File: test/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset, reset repeats on request
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 100,
    parameter int reset_cycles = 4
) (
    input  logic reset_req,
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        forever begin
            repeat (reset_cycles) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;           // released on a falling edge
            @(posedge reset_req);
            @(negedge clk);
            rst = 1'b1;
        end
    end

endmodule

// File: test/tb_render.sv
// ~~~~~~~~~~~~~~~~~~~~
// render testbench: scene model, directed tests, pixel stream checks
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_render;

    localparam int scale = 2;
    localparam int clk_period = 100;

    logic clk, rst, reset_req, oe, start;
    raster_pkg::coord_t x, y;
    raster_pkg::cidx_t cidx;
    logic drawing, done;

    // unscaled scene, one row per triangle
    int tab_x[3][3] = '{'{60, 280, 160}, '{70, 220, 170}, '{22, 62, 98}};
    int tab_y[3][3] = '{'{20, 80, 164}, '{160, 90, 10}, '{36, 150, 96}};
    int tab_c[3] = '{3, 2, 1};

    int exp_x[$], exp_y[$], exp_c[$];
    raster_pkg::coord_t got_x[$], got_y[$];
    raster_pkg::cidx_t got_c[$];
    int seed = 80906;
    int error_count = 0;
    int failed_tests = 0;
    bit model_ready = 1'b0;

    tb_clock #(.period(clk_period), .reset_cycles(4)) tb_clock_i (
        .reset_req(reset_req),
        .clk(clk),
        .rst(rst)
    );

    render_top #(.scale(scale)) render_top_i (
        .clk(clk),
        .rst(rst),
        .oe(oe),
        .start(start),
        .x(x),
        .y(y),
        .cidx(cidx),
        .drawing(drawing),
        .done(done)
    );

    bind render_top render_properties render_properties_i (
        .clk(clk),
        .rst(rst),
        .oe(oe),
        .x(x),
        .y(y),
        .drawing(drawing),
        .done(done)
    );

    // pixel capture, values before the edge
    always @(posedge clk) begin
        if (drawing === 1'b1) begin
            got_x.push_back(x);
            got_y.push_back(y);
            got_c.push_back(cidx);
        end
    end

    // integer Bresenham, both endpoints drawn
    task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                              input int c);
        int dx, dy, sx, sy, err, e2, px, py;
        dx = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
        sx = (x0 < x1) ? 1 : -1;
        sy = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        px = x0;
        py = y0;
        forever begin
            exp_x.push_back(px);
            exp_y.push_back(py);
            exp_c.push_back(c);
            if (px == x1 && py == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                px += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                py += sy;
            end
        end
    endtask

    task automatic build_model();
        int vx[3], vy[3];
        int s, v, e;
        for (s = 0; s < 3; s++) begin
            for (v = 0; v < 3; v++) begin
                vx[v] = tab_x[s][v] * scale;
                vy[v] = tab_y[s][v] * scale;
            end
            for (e = 0; e < 3; e++) begin  // v0-v1, v1-v2, v2-v0
                model_line(vx[e], vy[e], vx[(e + 1) % 3], vy[(e + 1) % 3], tab_c[s]);
            end
        end
    endtask

    task automatic check_coord(input string what, input raster_pkg::coord_t got,
                               input raster_pkg::coord_t exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_cidx(input string what, input raster_pkg::cidx_t got,
                              input raster_pkg::cidx_t exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            error_count++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset_req = 1'b1;
        @(posedge rst);
        @(negedge rst);
        reset_req = 1'b0;
        @(negedge clk);
    endtask

    // one start strobe, then oe and stray starts until done
    task automatic run_scene(input bit random_oe, input bit extra_starts);
        int cycles, r;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        cycles = 0;
        while (done !== 1'b1) begin
            @(negedge clk);
            cycles++;
            r = $random(seed);
            oe = random_oe ? r[0] : 1'b1;
            start = extra_starts && (cycles % 97 == 3);
        end
        oe = 1'b1;
        start = 1'b0;
    endtask

    task automatic compare_run(input int first);
        int n, i, errs;
        errs = error_count;
        n = got_x.size() - first;
        check_count("pixel count", n, exp_x.size());
        for (i = 0; i < n && i < exp_x.size(); i++) begin
            check_coord($sformatf("pixel %0d x", i), got_x[first + i],
                        raster_pkg::coord_t'(exp_x[i]));
            check_coord($sformatf("pixel %0d y", i), got_y[first + i],
                        raster_pkg::coord_t'(exp_y[i]));
            check_cidx($sformatf("pixel %0d cidx", i), got_c[first + i],
                       raster_pkg::cidx_t'(exp_c[i]));
            if (error_count > errs + 10) break;  // enough to see the pattern
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        repeat (20) begin
            @(posedge clk);
            check_bit("drawing", drawing, 1'b0);
            check_bit("done", done, 1'b0);
        end
        report_test("reset state", errs);
    endtask

    task automatic test_scene(input string name, input bit random_oe,
                              input bit extra_starts);
        int errs, first;
        errs = error_count;
        first = got_x.size();
        run_scene(random_oe, extra_starts);
        compare_run(first);
        report_test(name, errs);
    endtask

    task automatic test_completion();
        int errs;
        errs = error_count;
        repeat (50) begin
            @(posedge clk);
            check_bit("done", done, 1'b1);
            check_bit("drawing", drawing, 1'b0);
        end
        report_test("completion", errs);
    endtask

    initial begin
        oe = 1'b1;
        start = 1'b0;
        reset_req = 1'b0;
        build_model();
        model_ready = 1'b1;
        @(negedge rst);
        test_reset_state();
        test_scene("full scene", 1'b0, 1'b0);
        test_completion();
        apply_reset();
        test_scene("back-pressure", 1'b1, 1'b0);
        apply_reset();
        test_scene("start while busy", 1'b0, 1'b1);
        $display("tests run: 5, failed: %0d, errors: %0d", failed_tests, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // three scene runs, the stalled one near twice as long
    initial begin
        longint limit_ns;
        wait (model_ready);
        limit_ns = longint'(exp_x.size()) * 20 * clk_period + 100_000;
        #(limit_ns);
        $display("timeout: scene did not finish");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
